// File: rtl/mips_id_pkg.sv
package mips_id_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and function codes
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LH    = 6'h21;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LBU   = 6'h24;
    localparam logic [5:0] OP_LHU   = 6'h25;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SH    = 6'h29;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_JALR  = 6'h09;

    ////////////////////////////////////////////////////////////////////////////
    // Control field layouts
    ////////////////////////////////////////////////////////////////////////////
    // ex = {reg_dst, alu_src, alu_op[1:0]}
    localparam int EX_W          = 4;
    localparam int EX_REG_DST    = 3;
    localparam int EX_ALU_SRC    = 2;
    // mem = {mem_read, mem_write, branch}
    localparam int MEM_W         = 3;
    localparam int MEM_READ      = 2;
    localparam int MEM_WRITE     = 1;
    localparam int MEM_BRANCH    = 0;
    // wb = {reg_write, mem_to_reg}
    localparam int WB_W          = 2;
    localparam int WB_REG_WRITE  = 1;
    localparam int WB_MEM_TO_REG = 0;

    localparam logic [1:0] ALU_ADD   = 2'd0;
    localparam logic [1:0] ALU_SUB   = 2'd1;
    localparam logic [1:0] ALU_RTYPE = 2'd2;
    localparam logic [1:0] ALU_IMM   = 2'd3;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    localparam logic [4:0] REG_LINK  = 5'd31;

    typedef enum logic [2:0] {
        JK_NONE = 3'd0,
        JK_J    = 3'd1,
        JK_JAL  = 3'd2,
        JK_JR   = 3'd3,
        JK_JALR = 3'd4
    } jump_kind_e;

    // Instruction word in its three formats
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

endpackage

// File: rtl/id_control.sv
`timescale 1ns/1ns

module id_control import mips_id_pkg::*; (
    input  instr_u           i_instr,
    input  logic             i_bubble,
    output logic [EX_W-1:0]  o_ex,
    output logic [MEM_W-1:0] o_mem,
    output logic [WB_W-1:0]  o_wb,
    output logic [1:0]       o_sizemem,
    output logic             o_signedmem,
    output logic             o_beq_not_bne,
    output jump_kind_e       o_jump_kind,
    output logic             o_halt
);

    // Byte, half or word access for loads and stores
    function automatic logic [1:0] access_size(input logic [5:0] op);
        case (op)
            OP_LB, OP_LBU, OP_SB: access_size = SIZE_BYTE;
            OP_LH, OP_LHU, OP_SH: access_size = SIZE_HALF;
            default:              access_size = SIZE_WORD;
        endcase
    endfunction

    always_comb begin
        o_ex          = '0;
        o_mem         = '0;
        o_wb          = '0;
        o_sizemem     = '0;
        o_signedmem   = 1'b0;
        o_beq_not_bne = 1'b0;
        o_jump_kind   = JK_NONE;
        o_halt        = 1'b0;

        case (i_instr.r.opcode)
            OP_RTYPE: begin
                o_ex               = {1'b1, 1'b0, ALU_RTYPE};
                o_wb[WB_REG_WRITE] = 1'b1;
                if (i_instr.r.funct == FN_JR) begin
                    // jr writes nothing back
                    o_ex        = '0;
                    o_wb        = '0;
                    o_jump_kind = JK_JR;
                end else if (i_instr.r.funct == FN_JALR) begin
                    o_jump_kind = JK_JALR;
                end
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
                o_ex               = {1'b0, 1'b1, ALU_IMM};
                o_wb[WB_REG_WRITE] = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                o_ex            = {1'b0, 1'b1, ALU_ADD};
                o_mem[MEM_READ] = 1'b1;
                o_wb            = '1;
                o_sizemem       = access_size(i_instr.r.opcode);
                o_signedmem     = (i_instr.r.opcode != OP_LBU) &&
                                  (i_instr.r.opcode != OP_LHU);
            end
            OP_SB, OP_SH, OP_SW: begin
                o_ex             = {1'b0, 1'b1, ALU_ADD};
                o_mem[MEM_WRITE] = 1'b1;
                o_sizemem        = access_size(i_instr.r.opcode);
            end
            OP_BEQ, OP_BNE: begin
                o_ex              = {1'b0, 1'b0, ALU_SUB};
                o_mem[MEM_BRANCH] = 1'b1;
                o_beq_not_bne     = (i_instr.r.opcode == OP_BEQ);
            end
            OP_J: o_jump_kind = JK_J;
            OP_JAL: begin
                o_wb[WB_REG_WRITE] = 1'b1;
                o_jump_kind        = JK_JAL;
            end
            OP_HALT: o_halt = 1'b1;
            default: ;
        endcase

        // Bubble squashes everything, halt too
        if (i_bubble) begin
            o_ex          = '0;
            o_mem         = '0;
            o_wb          = '0;
            o_sizemem     = '0;
            o_signedmem   = 1'b0;
            o_beq_not_bne = 1'b0;
            o_jump_kind   = JK_NONE;
            o_halt        = 1'b0;
        end
    end

endmodule

// File: rtl/id_regfile.sv
`timescale 1ns/1ns

module id_regfile #(
    parameter int DATA_WIDTH = 32,
    parameter int NUM_REGS   = 32
) (
    input  logic                  i_clock,
    input  logic                  i_rst_n,
    input  logic                  i_regwrite,
    input  logic [4:0]            i_wr_addr,
    input  logic [DATA_WIDTH-1:0] i_wr_data,
    input  logic [4:0]            i_rs,
    input  logic [4:0]            i_rt,
    input  logic                  i_dbg_req,
    input  logic [4:0]            i_dbg_addr,
    output logic [DATA_WIDTH-1:0] o_reg_a,
    output logic [DATA_WIDTH-1:0] o_reg_b,
    output logic                  o_dbg_ack,
    output logic [DATA_WIDTH-1:0] o_dbg_data
);

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    // Register 0 is hardwired; a write in flight is forwarded
    function automatic logic [DATA_WIDTH-1:0] read_reg(input logic [4:0] addr);
        if (addr == '0)
            read_reg = '0;
        else if (i_regwrite && (addr == i_wr_addr))
            read_reg = i_wr_data;
        else
            read_reg = regs[addr];
    endfunction

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int k = 0; k < NUM_REGS; k++)
                regs[k] <= '0;
        end else if (i_regwrite && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    always_comb begin
        o_reg_a = read_reg(i_rs);
        o_reg_b = read_reg(i_rt);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Debug readout, four-phase req/ack
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dbg_ack  <= 1'b0;
            o_dbg_data <= '0;
        end else if (i_dbg_req && !o_dbg_ack) begin
            o_dbg_ack  <= 1'b1;
            o_dbg_data <= read_reg(i_dbg_addr);
        end else if (!i_dbg_req) begin
            // Data stays put until the next request
            o_dbg_ack <= 1'b0;
        end
    end

endmodule

// File: rtl/id_branch_unit.sv
`timescale 1ns/1ns

module id_branch_unit #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [15:0]           i_imm,
    input  logic [DATA_WIDTH-1:0] i_pc_plus4,
    input  logic [DATA_WIDTH-1:0] i_reg_a,
    input  logic [DATA_WIDTH-1:0] i_reg_b,
    input  logic                  i_branch,
    input  logic                  i_beq_not_bne,
    output logic [DATA_WIDTH-1:0] o_imm_ext,
    output logic [DATA_WIDTH-1:0] o_pc_branch,
    output logic                  o_branch
);

    logic operands_equal;

    assign o_imm_ext = {{(DATA_WIDTH-16){i_imm[15]}}, i_imm};

    // Word offset from the delay-slot address
    assign o_pc_branch = i_pc_plus4 + (o_imm_ext << 2);

    assign operands_equal = (i_reg_a == i_reg_b);

    // Resolved here in decode, not in execute
    assign o_branch = i_branch & (i_beq_not_bne ? operands_equal : ~operands_equal);

endmodule

// File: rtl/id_jump_unit.sv
`timescale 1ns/1ns

module id_jump_unit import mips_id_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  jump_kind_e            i_jump_kind,
    input  logic [25:0]           i_index,
    input  logic [4:0]            i_rd_field,
    input  logic [DATA_WIDTH-1:0] i_pc_plus4,
    input  logic [DATA_WIDTH-1:0] i_reg_a,
    output logic [DATA_WIDTH-1:0] o_pc_jump,
    output logic                  o_jump,
    output logic [DATA_WIDTH-1:0] o_return_addr,
    output logic                  o_return,
    output logic [4:0]            o_rd
);

    logic [DATA_WIDTH-1:0] region_target;

    // Pseudo-direct target stays inside the current 256 MB region
    assign region_target = {i_pc_plus4[DATA_WIDTH-1:28], i_index, 2'b00};

    always_comb begin
        case (i_jump_kind)
            JK_JR, JK_JALR: o_pc_jump = i_reg_a;
            default:        o_pc_jump = region_target;
        endcase
    end

    assign o_jump = (i_jump_kind != JK_NONE);

    // Link skips the delay slot
    assign o_return_addr = i_pc_plus4 + DATA_WIDTH'(4);
    assign o_return      = (i_jump_kind == JK_JAL) || (i_jump_kind == JK_JALR);

    assign o_rd = (i_jump_kind == JK_JAL) ? REG_LINK : i_rd_field;

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ns

module id_stage import mips_id_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int NUM_REGS   = 32
) (
    input  logic                  i_clock,
    input  logic                  i_rst_n,
    input  instr_u                i_instr,
    input  logic [DATA_WIDTH-1:0] i_pc_plus4,
    input  logic                  i_bubble,
    input  logic                  i_regwrite,
    input  logic [4:0]            i_wr_addr,
    input  logic [DATA_WIDTH-1:0] i_wr_data,
    input  logic                  i_dbg_req,
    input  logic [4:0]            i_dbg_addr,
    output logic [DATA_WIDTH-1:0] o_reg_a,
    output logic [DATA_WIDTH-1:0] o_reg_b,
    output logic [DATA_WIDTH-1:0] o_imm_ext,
    output logic [DATA_WIDTH-1:0] o_pc_branch,
    output logic                  o_branch,
    output logic [5:0]            o_opcode,
    output logic [4:0]            o_rs,
    output logic [4:0]            o_rt,
    output logic [4:0]            o_rd,
    output logic [EX_W-1:0]       o_ex,
    output logic [MEM_W-1:0]      o_mem,
    output logic [WB_W-1:0]       o_wb,
    output logic [1:0]            o_sizemem,
    output logic                  o_signedmem,
    output logic [DATA_WIDTH-1:0] o_pc_jump,
    output logic                  o_jump,
    output logic [DATA_WIDTH-1:0] o_return_addr,
    output logic                  o_return,
    output logic                  o_halt,
    output logic                  o_dbg_ack,
    output logic [DATA_WIDTH-1:0] o_dbg_data
);

    logic       beq_not_bne;
    jump_kind_e jump_kind;

    assign o_opcode = i_instr.r.opcode;
    assign o_rs     = i_instr.r.rs;
    assign o_rt     = i_instr.r.rt;

    id_control u_control (
        .i_instr       (i_instr),
        .i_bubble      (i_bubble),
        .o_ex          (o_ex),
        .o_mem         (o_mem),
        .o_wb          (o_wb),
        .o_sizemem     (o_sizemem),
        .o_signedmem   (o_signedmem),
        .o_beq_not_bne (beq_not_bne),
        .o_jump_kind   (jump_kind),
        .o_halt        (o_halt)
    );

    id_regfile #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_REGS   (NUM_REGS)
    ) u_regfile (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_regwrite (i_regwrite),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .i_rs       (i_instr.r.rs),
        .i_rt       (i_instr.r.rt),
        .i_dbg_req  (i_dbg_req),
        .i_dbg_addr (i_dbg_addr),
        .o_reg_a    (o_reg_a),
        .o_reg_b    (o_reg_b),
        .o_dbg_ack  (o_dbg_ack),
        .o_dbg_data (o_dbg_data)
    );

    // Branch bit taken after the bubble mux
    id_branch_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_branch (
        .i_imm         (i_instr.i.imm),
        .i_pc_plus4    (i_pc_plus4),
        .i_reg_a       (o_reg_a),
        .i_reg_b       (o_reg_b),
        .i_branch      (o_mem[MEM_BRANCH]),
        .i_beq_not_bne (beq_not_bne),
        .o_imm_ext     (o_imm_ext),
        .o_pc_branch   (o_pc_branch),
        .o_branch      (o_branch)
    );

    id_jump_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_jump (
        .i_jump_kind   (jump_kind),
        .i_index       (i_instr.j.index),
        .i_rd_field    (i_instr.r.rd),
        .i_pc_plus4    (i_pc_plus4),
        .i_reg_a       (o_reg_a),
        .o_pc_jump     (o_pc_jump),
        .o_jump        (o_jump),
        .o_return_addr (o_return_addr),
        .o_return      (o_return),
        .o_rd          (o_rd)
    );

endmodule

// File: dv/id_stage_props.sv
`timescale 1ns/1ns

module id_stage_props import mips_id_pkg::*; (
    input logic             i_clock,
    input logic             i_rst_n,
    input logic             i_bubble,
    input logic             i_dbg_req,
    input logic             i_dbg_ack,
    input logic [EX_W-1:0]  i_ex,
    input logic [MEM_W-1:0] i_mem,
    input logic [WB_W-1:0]  i_wb,
    input logic [1:0]       i_sizemem,
    input logic             i_signedmem,
    input logic             i_halt,
    input jump_kind_e       i_jump_kind,
    input logic [4:0]       i_rd
);

    // Ack answers a request one edge later
    ack_follows_req: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_dbg_req && !i_dbg_ack) |=> i_dbg_ack)
        else $error("debug ack did not rise one edge after the request");

    ack_rise_needs_req: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $rose(i_dbg_ack) |-> $past(i_dbg_req))
        else $error("debug ack rose without a pending request");

    ack_fall_after_req: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $fell(i_dbg_ack) |-> !$past(i_dbg_req))
        else $error("debug ack fell while the request was still high");

    bubble_clears_control: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_bubble |-> ((i_ex == '0) && (i_mem == '0) && (i_wb == '0) && (i_sizemem == '0) &&
                      !i_signedmem && !i_halt && (i_jump_kind == JK_NONE)))
        else $error("control output set during a bubble");

    jal_links_r31: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_jump_kind == JK_JAL) |-> (i_rd == REG_LINK))
        else $error("jal does not target the link register");

endmodule

bind id_stage id_stage_props u_props (
    .i_clock     (i_clock),
    .i_rst_n     (i_rst_n),
    .i_bubble    (i_bubble),
    .i_dbg_req   (i_dbg_req),
    .i_dbg_ack   (o_dbg_ack),
    .i_ex        (o_ex),
    .i_mem       (o_mem),
    .i_wb        (o_wb),
    .i_sizemem   (o_sizemem),
    .i_signedmem (o_signedmem),
    .i_halt      (o_halt),
    .i_jump_kind (jump_kind),
    .i_rd        (o_rd)
);

// File: dv/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage import mips_id_pkg::*;;

    localparam int          CLK_PERIOD = 40;
    localparam int          NUM_DBG    = 5;
    localparam logic [31:0] PC_BASE    = 32'h0040_0100;
    localparam logic [5:0]  FN_ADD     = 6'h20;
    // Expected jump target source
    localparam logic [1:0]  JT_NONE    = 2'd0;
    localparam logic [1:0]  JT_DIRECT  = 2'd1;
    localparam logic [1:0]  JT_REG     = 2'd2;

    typedef struct {
        string       name;
        logic [31:0] instr;
        logic [31:0] pc_plus4;
        logic        bubble;
        logic        wr;
        logic [4:0]  wr_addr;
        logic [31:0] wr_data;
        logic [3:0]  ex;
        logic [2:0]  mem;
        logic [1:0]  wb;
        logic [1:0]  size;
        logic        sgn;
        logic        halt;
        logic [1:0]  jk;
        logic        ret;
        logic        link;
    } row_t;

    logic        i_clock;
    logic        i_rst_n;
    instr_u      i_instr;
    logic [31:0] i_pc_plus4;
    logic        i_bubble;
    logic        i_regwrite;
    logic [4:0]  i_wr_addr;
    logic [31:0] i_wr_data;
    logic        i_dbg_req;
    logic [4:0]  i_dbg_addr;
    logic [31:0] o_reg_a;
    logic [31:0] o_reg_b;
    logic [31:0] o_imm_ext;
    logic [31:0] o_pc_branch;
    logic        o_branch;
    logic [5:0]  o_opcode;
    logic [4:0]  o_rs;
    logic [4:0]  o_rt;
    logic [4:0]  o_rd;
    logic [3:0]  o_ex;
    logic [2:0]  o_mem;
    logic [1:0]  o_wb;
    logic [1:0]  o_sizemem;
    logic        o_signedmem;
    logic [31:0] o_pc_jump;
    logic        o_jump;
    logic [31:0] o_return_addr;
    logic        o_return;
    logic        o_halt;
    logic        o_dbg_ack;
    logic [31:0] o_dbg_data;

    row_t        rows[$];
    logic [31:0] shadow [32];
    logic [4:0]  dbg_regs [NUM_DBG] = '{5'd1, 5'd6, 5'd9, 5'd17, 5'd31};
    integer      seed;
    longint      limit;

    id_stage UUT (.*);

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] funct);
        r_word = {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        i_word = {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [25:0] index);
        j_word = {op, index};
    endfunction

    // r0 is zero; a write in the same cycle is seen at once
    function automatic logic [31:0] expected_operand(input logic [4:0] addr, input row_t r);
        if (addr == 5'd0)
            expected_operand = '0;
        else if (r.wr && (addr == r.wr_addr))
            expected_operand = r.wr_data;
        else
            expected_operand = shadow[addr];
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: %s expected %h actual %h", test, field, expected, actual);
            abort_run();
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] instr,
                           input logic [31:0] pc, input logic bubble, input logic [3:0] ex,
                           input logic [2:0] mem, input logic [1:0] wb,
                           input logic [1:0] size, input logic sgn, input logic halt,
                           input logic [1:0] jk, input logic ret, input logic link);
        row_t r;
        r.name     = name;
        r.instr    = instr;
        r.pc_plus4 = pc;
        r.bubble   = bubble;
        r.wr       = 1'b0;
        r.wr_addr  = 5'd0;
        r.wr_data  = '0;
        r.ex       = ex;
        r.mem      = mem;
        r.wb       = wb;
        r.size     = size;
        r.sgn      = sgn;
        r.halt     = halt;
        r.jk       = jk;
        r.ret      = ret;
        r.link     = link;
        rows.push_back(r);
    endtask

    // Adds a register write to the last row
    task automatic with_write(input logic [4:0] addr, input logic [31:0] data);
        rows[rows.size() - 1].wr      = 1'b1;
        rows[rows.size() - 1].wr_addr = addr;
        rows[rows.size() - 1].wr_data = data;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_table();
        add_row("add", r_word(5'd3, 5'd4, 5'd5, FN_ADD), PC_BASE, 1'b0,
                4'b1010, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("write_r0", r_word(5'd0, 5'd7, 5'd2, FN_ADD), PC_BASE, 1'b0,
                4'b1010, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        with_write(5'd0, 32'hdead_beef);
        add_row("read_r0", r_word(5'd0, 5'd0, 5'd3, FN_ADD), PC_BASE, 1'b0,
                4'b1010, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("fwd_r6", r_word(5'd6, 5'd6, 5'd1, FN_ADD), PC_BASE, 1'b0,
                4'b1010, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        with_write(5'd6, 32'h1234_5678);
        add_row("after_fwd", r_word(5'd6, 5'd7, 5'd1, FN_ADD), PC_BASE, 1'b0,
                4'b1010, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("addi", i_word(OP_ADDI, 5'd10, 5'd11, 16'h8000), PC_BASE, 1'b0,
                4'b0111, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("ori", i_word(OP_ORI, 5'd2, 5'd3, 16'h00ff), PC_BASE, 1'b0,
                4'b0111, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("lw", i_word(OP_LW, 5'd12, 5'd13, 16'h0040), PC_BASE, 1'b0,
                4'b0100, 3'b100, 2'b11, SIZE_WORD, 1'b1, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("lh", i_word(OP_LH, 5'd12, 5'd13, 16'hfffe), PC_BASE, 1'b0,
                4'b0100, 3'b100, 2'b11, SIZE_HALF, 1'b1, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("lbu", i_word(OP_LBU, 5'd14, 5'd15, 16'h0003), PC_BASE, 1'b0,
                4'b0100, 3'b100, 2'b11, SIZE_BYTE, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("lhu", i_word(OP_LHU, 5'd14, 5'd15, 16'h0002), PC_BASE, 1'b0,
                4'b0100, 3'b100, 2'b11, SIZE_HALF, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("sb", i_word(OP_SB, 5'd16, 5'd17, 16'h0001), PC_BASE, 1'b0,
                4'b0100, 3'b010, 2'b00, SIZE_BYTE, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("sw", i_word(OP_SW, 5'd16, 5'd17, 16'h0100), PC_BASE, 1'b0,
                4'b0100, 3'b010, 2'b00, SIZE_WORD, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        // r8 and r9 hold the same value
        add_row("beq_taken", i_word(OP_BEQ, 5'd8, 5'd9, 16'h0010), PC_BASE, 1'b0,
                4'b0001, 3'b001, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("beq_not_taken", i_word(OP_BEQ, 5'd8, 5'd10, 16'hfff0), PC_BASE, 1'b0,
                4'b0001, 3'b001, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("bne_taken", i_word(OP_BNE, 5'd8, 5'd10, 16'hffff), PC_BASE, 1'b0,
                4'b0001, 3'b001, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("bne_not_taken", i_word(OP_BNE, 5'd8, 5'd9, 16'h0004), PC_BASE, 1'b0,
                4'b0001, 3'b001, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("j", j_word(OP_J, 26'h123_4567), 32'hb000_0010, 1'b0,
                4'b0000, 3'b000, 2'b00, 2'd0, 1'b0, 1'b0, JT_DIRECT, 1'b0, 1'b0);
        add_row("jal", j_word(OP_JAL, 26'h0ab_cdef), 32'h7fff_fffc, 1'b0,
                4'b0000, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_DIRECT, 1'b1, 1'b1);
        add_row("jr", r_word(5'd12, 5'd0, 5'd0, FN_JR), PC_BASE, 1'b0,
                4'b0000, 3'b000, 2'b00, 2'd0, 1'b0, 1'b0, JT_REG, 1'b0, 1'b0);
        add_row("jalr", r_word(5'd13, 5'd0, 5'd14, FN_JALR), PC_BASE, 1'b0,
                4'b1010, 3'b000, 2'b10, 2'd0, 1'b0, 1'b0, JT_REG, 1'b1, 1'b0);
        add_row("halt", {OP_HALT, 26'd0}, PC_BASE, 1'b0,
                4'b0000, 3'b000, 2'b00, 2'd0, 1'b0, 1'b1, JT_NONE, 1'b0, 1'b0);
        // Bubbled rows decode to nothing
        add_row("bubble_add", r_word(5'd3, 5'd4, 5'd5, FN_ADD), PC_BASE, 1'b1,
                4'b0000, 3'b000, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("bubble_lw", i_word(OP_LW, 5'd12, 5'd13, 16'h0040), PC_BASE, 1'b1,
                4'b0000, 3'b000, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("bubble_beq", i_word(OP_BEQ, 5'd8, 5'd9, 16'h0010), PC_BASE, 1'b1,
                4'b0000, 3'b000, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("bubble_jal", j_word(OP_JAL, 26'h0ab_cdef), 32'h7fff_fffc, 1'b1,
                4'b0000, 3'b000, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
        add_row("bubble_halt", {OP_HALT, 26'd0}, PC_BASE, 1'b1,
                4'b0000, 3'b000, 2'b00, 2'd0, 1'b0, 1'b0, JT_NONE, 1'b0, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers and checkers
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_registers();
        shadow[0] = '0;
        for (int k = 1; k < 32; k++) begin
            @(posedge i_clock);
            #5;
            // r9 copies r8 for a taken beq
            shadow[k]  = (k == 9) ? shadow[8] : $random(seed);
            i_regwrite = 1'b1;
            i_wr_addr  = 5'(k);
            i_wr_data  = shadow[k];
        end
        @(posedge i_clock);
        #5;
        i_regwrite = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        logic [31:0] exp_imm;
        logic [31:0] exp_target;
        logic        exp_br;
        logic [4:0]  exp_rd;
        @(posedge i_clock);
        #5;
        i_instr    = r.instr;
        i_pc_plus4 = r.pc_plus4;
        i_bubble   = r.bubble;
        i_regwrite = r.wr;
        i_wr_addr  = r.wr_addr;
        i_wr_data  = r.wr_data;
        exp_a      = expected_operand(r.instr[25:21], r);
        exp_b      = expected_operand(r.instr[20:16], r);
        exp_imm    = {{16{r.instr[15]}}, r.instr[15:0]};
        exp_br     = r.mem[0] &&
                     ((r.instr[31:26] == OP_BEQ) ? (exp_a == exp_b) : (exp_a != exp_b));
        exp_target = (r.jk == JT_REG) ? exp_a : {r.pc_plus4[31:28], r.instr[25:0], 2'b00};
        exp_rd     = r.link ? REG_LINK : r.instr[15:11];
        // Sample just before the next edge
        #30;
        check_value(r.name, "opcode", 32'(r.instr[31:26]), 32'(o_opcode));
        check_value(r.name, "rs", 32'(r.instr[25:21]), 32'(o_rs));
        check_value(r.name, "rt", 32'(r.instr[20:16]), 32'(o_rt));
        check_value(r.name, "reg_a", exp_a, o_reg_a);
        check_value(r.name, "reg_b", exp_b, o_reg_b);
        check_value(r.name, "imm_ext", exp_imm, o_imm_ext);
        check_value(r.name, "pc_branch", r.pc_plus4 + (exp_imm << 2), o_pc_branch);
        check_value(r.name, "branch", 32'(exp_br), 32'(o_branch));
        check_value(r.name, "ex", 32'(r.ex), 32'(o_ex));
        check_value(r.name, "mem", 32'(r.mem), 32'(o_mem));
        check_value(r.name, "wb", 32'(r.wb), 32'(o_wb));
        check_value(r.name, "sizemem", 32'(r.size), 32'(o_sizemem));
        check_value(r.name, "signedmem", 32'(r.sgn), 32'(o_signedmem));
        check_value(r.name, "halt", 32'(r.halt), 32'(o_halt));
        check_value(r.name, "jump", 32'(r.jk != JT_NONE), 32'(o_jump));
        if (r.jk != JT_NONE)
            check_value(r.name, "pc_jump", exp_target, o_pc_jump);
        check_value(r.name, "return_addr", r.pc_plus4 + 32'd4, o_return_addr);
        check_value(r.name, "return", 32'(r.ret), 32'(o_return));
        check_value(r.name, "rd", 32'(exp_rd), 32'(o_rd));
        if (r.wr && (r.wr_addr != 5'd0))
            shadow[r.wr_addr] = r.wr_data;
    endtask

    // Four-phase read through the debug port
    task automatic debug_read(input logic [4:0] addr);
        int waited;
        @(posedge i_clock);
        #5;
        i_dbg_addr = addr;
        i_dbg_req  = 1'b1;
        waited     = 0;
        do begin
            @(posedge i_clock);
            #5;
            waited++;
        end while (!o_dbg_ack && (waited < 8));
        assert (o_dbg_ack === 1'b1) else begin
            $display("Debug ack never rose for a read of register %0d", addr);
            abort_run();
        end
        check_value($sformatf("debug_r%0d", addr), "dbg_data", shadow[addr], o_dbg_data);
        i_dbg_req = 1'b0;
        waited    = 0;
        do begin
            @(posedge i_clock);
            #5;
            waited++;
        end while (o_dbg_ack && (waited < 8));
        assert (o_dbg_ack === 1'b0) else begin
            $display("Debug ack stayed high after the request for register %0d fell", addr);
            abort_run();
        end
    endtask

    initial begin
        seed       = 22313;
        i_rst_n    = 1'b0;
        i_instr    = '0;
        i_pc_plus4 = '0;
        i_bubble   = 1'b0;
        i_regwrite = 1'b0;
        i_wr_addr  = '0;
        i_wr_data  = '0;
        i_dbg_req  = 1'b0;
        i_dbg_addr = '0;
        build_table();
        repeat (4) @(posedge i_clock);
        #5;
        i_rst_n = 1'b1;
        check_value("reset", "dbg_ack", 32'd0, 32'(o_dbg_ack));
        check_value("reset", "dbg_data", 32'd0, o_dbg_data);
        load_registers();
        foreach (rows[n])
            apply_row(rows[n]);
        @(posedge i_clock);
        #5;
        i_regwrite = 1'b0;
        i_bubble   = 1'b0;
        foreach (dbg_regs[n])
            debug_read(dbg_regs[n]);
        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog sized from the table and the debug reads
    initial begin
        #1;
        limit = longint'(rows.size() + 64 + 8 * NUM_DBG) * CLK_PERIOD;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        abort_run();
    end

endmodule

// File: src.f
rtl/mips_id_pkg.sv
rtl/id_control.sv
rtl/id_regfile.sv
rtl/id_branch_unit.sv
rtl/id_jump_unit.sv
rtl/id_stage.sv
dv/id_stage_props.sv
dv/tb_id_stage.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_id_stage
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= *** PASSED ***
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
